// ==== rtl/prc_reg_pkg.sv ====
`default_nettype none

package prc_reg_pkg;

    typedef logic [23:0] reg_addr_t;

    localparam reg_addr_t ADDR_MODE    = 24'h002080; // Stage control
    localparam reg_addr_t ADDR_RATE    = 24'h002081; // Rate control
    localparam reg_addr_t ADDR_COUNTER = 24'h00208A; // Line counter, read only

    // Stage control, bit 3 enables the frame copy
    typedef logic [5:0] mode_t;

    typedef logic [2:0] rate_code_t;  // Divider selector, rate bits 3:1
    typedef logic [3:0] skip_count_t; // Skipped frames, rate bits 7:4
    typedef logic [6:0] line_t;

    // Frame timing in lines
    localparam line_t LINE_FIRST  = 7'h01;
    localparam line_t LINE_ACTIVE = 7'h18; // Copy window opens
    localparam line_t LINE_LAST   = 7'h42; // Frame wraps back to LINE_FIRST

endpackage

`default_nettype wire

// ==== rtl/prc_bus_pkg.sv ====
`default_nettype none

package prc_bus_pkg;

    typedef logic [23:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // Driven on bus_status
    typedef enum logic [1:0]
    {
        IDLE      = 2'd0,
        IRQ_READ  = 2'd1,
        MEM_WRITE = 2'd2,
        MEM_READ  = 2'd3
    } bus_cmd_e;

    localparam bus_addr_t VRAM_BASE     = 24'h001000; // Finished frame, page major
    localparam bus_addr_t LCD_CMD_ADDR  = 24'h0020FE;
    localparam bus_addr_t LCD_DATA_ADDR = 24'h0020FF;

    // LCD geometry
    localparam int LCD_COLUMNS = 96;
    localparam int LCD_PAGES   = 8; // Eight rows of pixels per page byte

    typedef logic [2:0] page_t;
    typedef logic [6:0] column_t;

endpackage

`default_nettype wire

// ==== rtl/prc_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module prc_regs
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     bus_write,
    input  wire prc_reg_pkg::reg_addr_t   bus_address_in,
    input  wire logic [7:0]               bus_data_in,
    input  wire prc_reg_pkg::skip_count_t skip_count,
    input  wire prc_reg_pkg::line_t       line,
    output logic [7:0]                    reg_data_out,
    output prc_reg_pkg::mode_t            mode,
    output prc_reg_pkg::rate_code_t       rate_code,
    output logic                          rate_low_bit,
    output logic                          skip_clear
);
    import prc_reg_pkg::*;

    logic mode_write;
    logic rate_write;

    assign mode_write = bus_write && (bus_address_in == ADDR_MODE);
    assign rate_write = bus_write && (bus_address_in == ADDR_RATE);

    // New divider restarts the skip count on the same edge
    assign skip_clear = rate_write && (bus_data_in[3:1] != rate_code);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            mode         <= '0;
            rate_code    <= '0;
            rate_low_bit <= 1'b0;
        end
        else
        begin
            if (mode_write)
                mode <= bus_data_in[5:0];
            if (rate_write)
            begin
                rate_code    <= bus_data_in[3:1];
                rate_low_bit <= bus_data_in[0]; // Stored for readback only
            end
        end
    end

    always_comb
    begin
        case (bus_address_in)
            ADDR_MODE:
                reg_data_out = {2'b00, mode};
            ADDR_RATE:
                reg_data_out = {skip_count, rate_code, rate_low_bit};
            ADDR_COUNTER:
                reg_data_out = {1'b0, line};
            default:
                reg_data_out = 8'h00; // Map, sprite and scroll registers read as zero
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/prc_frame_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module prc_frame_timer
#(
    parameter int LINE_PERIOD = 855
)
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire prc_reg_pkg::mode_t       mode,
    input  wire prc_reg_pkg::rate_code_t  rate_code,
    input  wire logic                     skip_clear,
    input  wire logic                     bus_ack,
    input  wire logic                     busy,
    input  wire logic                     copy_done,
    output prc_reg_pkg::skip_count_t      skip_count,
    output prc_reg_pkg::line_t            line,
    output logic                          copy_start,
    output logic                          bus_request,
    output logic                          irq_render_done,
    output logic                          irq_copy_complete
);
    import prc_reg_pkg::*;

    localparam int OSC_WIDTH = $clog2(LINE_PERIOD);

    logic [OSC_WIDTH-1:0] osc_count;
    logic                 tick;
    line_t                line_next;
    logic                 frame_end;
    logic                 in_window;
    skip_count_t          rate_match;
    logic                 active;
    logic                 copy_ran;        // A copy already owned the bus this frame
    logic                 release_pending; // Frame ended while the copy was still busy

    // Match value is the divisor minus one
    always_comb
    begin
        case (rate_code)
            3'd0: rate_match = 4'd2;
            3'd1: rate_match = 4'd5;
            3'd2: rate_match = 4'd8;
            3'd3: rate_match = 4'd11;
            3'd4: rate_match = 4'd1;
            3'd5: rate_match = 4'd3;
            3'd6: rate_match = 4'd5;
            3'd7: rate_match = 4'd7;
        endcase
    end

    // Ticks are named by the line they lead into, so a frame is 65 ticks
    assign tick      = osc_count == OSC_WIDTH'(LINE_PERIOD - 1);
    assign line_next = line + 7'd1;
    assign frame_end = tick && (line_next == LINE_LAST);
    assign in_window = (line_next >= LINE_ACTIVE) && (line_next < LINE_LAST);
    assign active    = skip_count == rate_match;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            osc_count  <= '0;
            line       <= LINE_FIRST;
            skip_count <= '0;
        end
        else
        begin
            osc_count <= tick ? '0 : osc_count + OSC_WIDTH'(1);
            if (tick)
                line <= frame_end ? LINE_FIRST : line_next;
            if (skip_clear)
                skip_count <= '0;
            else if (frame_end)
                skip_count <= active ? '0 : skip_count + 4'd1;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            copy_start        <= 1'b0;
            bus_request       <= 1'b0;
            irq_render_done   <= 1'b0;
            irq_copy_complete <= 1'b0;
            copy_ran          <= 1'b0;
            release_pending   <= 1'b0;
        end
        else
        begin
            copy_start <= 1'b0;
            if (busy && bus_ack)
                copy_ran <= 1'b1;

            if (tick)
            begin
                irq_render_done   <= 1'b0; // Interrupt levels last one line
                irq_copy_complete <= 1'b0;
                if (active && mode[3] && in_window)
                begin
                    bus_request <= 1'b1;
                    copy_start  <= !busy && !copy_ran;
                end
                if (frame_end)
                begin
                    copy_ran <= 1'b0;
                    if (active)
                        irq_render_done <= 1'b1;
                    if (busy)
                        release_pending <= bus_request;
                    else
                        bus_request <= 1'b0;
                end
            end

            if (copy_done)
            begin
                irq_copy_complete <= 1'b1;
                if (release_pending)
                begin
                    bus_request     <= 1'b0;
                    release_pending <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/prc_frame_copy.sv ====
`timescale 1ns/1ps
`default_nettype none

module prc_frame_copy
(
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    copy_start,
    input  wire logic                    bus_ack,
    input  wire prc_bus_pkg::bus_data_t  bus_data_in,
    output logic                         busy,
    output logic                         copy_done,
    output prc_bus_pkg::bus_addr_t       bus_address_out,
    output prc_bus_pkg::bus_data_t       data_out,
    output prc_bus_pkg::bus_cmd_e        bus_status,
    output logic                         read,
    output logic                         write
);
    typedef enum logic [2:0]
    {
        COLUMN_SET1,
        COLUMN_SET2,
        PAGE_SET,
        MEM_READ,
        LCD_WRITE
    } state_e;

    // Bus commands stay scoped because MEM_READ names a state too
    import prc_bus_pkg::*;

    localparam column_t LAST_COLUMN = column_t'(LCD_COLUMNS - 1);
    localparam page_t   LAST_PAGE   = page_t'(LCD_PAGES - 1);

    state_e    state;
    page_t     page;
    column_t   column;
    logic      phase;     // Low for the setup clock, high for the strobe clock
    logic      op_setup;
    logic      op_strobe;
    bus_addr_t vram_addr;

    assign op_setup  = busy && bus_ack && !phase;
    assign op_strobe = busy && bus_ack && phase;
    assign vram_addr = VRAM_BASE + bus_addr_t'(page) * bus_addr_t'(LCD_COLUMNS)
                     + bus_addr_t'(column);

    assign read  = op_strobe && (bus_status == prc_bus_pkg::MEM_READ);
    assign write = op_strobe && (bus_status == prc_bus_pkg::MEM_WRITE);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy       <= 1'b0;
            copy_done  <= 1'b0;
            state      <= COLUMN_SET1;
            page       <= '0;
            column     <= '0;
            phase      <= 1'b0;
            bus_status <= IDLE;
        end
        else
        begin
            copy_done <= 1'b0;
            if (copy_start && !busy)
            begin
                busy   <= 1'b1;
                state  <= COLUMN_SET1;
                page   <= '0;
                column <= '0;
                phase  <= 1'b0;
            end
            else if (op_setup)
            begin
                phase      <= 1'b1;
                bus_status <= (state == MEM_READ) ? prc_bus_pkg::MEM_READ
                                                  : prc_bus_pkg::MEM_WRITE;
            end
            else if (op_strobe)
            begin
                phase <= 1'b0;
                case (state)
                    COLUMN_SET1: state <= COLUMN_SET2;
                    COLUMN_SET2: state <= PAGE_SET;
                    PAGE_SET:    state <= MEM_READ;
                    MEM_READ:    state <= LCD_WRITE;
                    default:
                    begin
                        column <= column + 7'd1;
                        state  <= MEM_READ;
                        if (column == LAST_COLUMN)
                        begin
                            column <= '0;
                            page   <= page + 3'd1;
                            state  <= COLUMN_SET1;
                            if (page == LAST_PAGE)
                            begin
                                busy       <= 1'b0;
                                copy_done  <= 1'b1;
                                bus_status <= IDLE;
                            end
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (op_setup)
        begin
            case (state)
                COLUMN_SET1:
                begin
                    bus_address_out <= LCD_CMD_ADDR;
                    data_out        <= 8'h10; // Column address high nibble
                end
                COLUMN_SET2:
                begin
                    bus_address_out <= LCD_CMD_ADDR;
                    data_out        <= 8'h00;
                end
                PAGE_SET:
                begin
                    bus_address_out <= LCD_CMD_ADDR;
                    data_out        <= {5'b10110, page};
                end
                MEM_READ:
                    bus_address_out <= vram_addr;
                default:
                    bus_address_out <= LCD_DATA_ADDR; // Byte from the read just before
            endcase
        end
        else if (op_strobe && state == MEM_READ)
            data_out <= bus_data_in;
    end

endmodule

`default_nettype wire

// ==== rtl/prc.sv ====
`timescale 1ns/1ps
`default_nettype none

module prc
#(
    parameter int LINE_PERIOD = 855
)
(
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    bus_write,
    input  wire prc_reg_pkg::reg_addr_t  bus_address_in,
    input  wire prc_bus_pkg::bus_data_t  bus_data_in,
    output prc_bus_pkg::bus_data_t       bus_data_out,
    output prc_bus_pkg::bus_addr_t       bus_address_out,
    output prc_bus_pkg::bus_cmd_e        bus_status,
    output logic                         write,
    output logic                         read,
    output logic                         bus_request,
    input  wire logic                    bus_ack,
    output logic                         irq_copy_complete,
    output logic                         irq_render_done
);
    import prc_reg_pkg::*;
    import prc_bus_pkg::*;

    bus_data_t   reg_data_out;
    bus_data_t   data_out;
    mode_t       mode;
    rate_code_t  rate_code;
    logic        skip_clear;
    skip_count_t skip_count;
    line_t       line;
    logic        copy_start;
    logic        busy;
    logic        copy_done;

    // Master data owns the shared output while granted
    assign bus_data_out = bus_ack ? data_out : reg_data_out;

    prc_regs i_regs
    (
        .*,
        .rate_low_bit ()
    );

    prc_frame_timer #(.LINE_PERIOD(LINE_PERIOD)) i_frame_timer (.*);

    prc_frame_copy i_frame_copy (.*);

endmodule

`default_nettype wire

// ==== tests/prc_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module prc_assertions
(
    input wire logic clk,
    input wire logic reset,
    input wire logic read,
    input wire logic write,
    input wire logic bus_ack
);
    int failure_count = 0;

    strobes_exclusive: assert property (@(posedge clk) disable iff (reset) !(read && write))
    else
    begin
        failure_count++;
        $error("read and write strobes are high together");
    end

    // Every operation spends one setup clock between strobes
    strobe_one_clock: assert property (@(posedge clk) disable iff (reset)
        (read || write) |=> !(read || write))
    else
    begin
        failure_count++;
        $error("a master strobe lasted longer than one clock");
    end

    strobe_granted: assert property (@(posedge clk) disable iff (reset)
        (read || write) |-> bus_ack)
    else
    begin
        failure_count++;
        $error("a master strobe came while bus_ack was low");
    end

endmodule

`default_nettype wire

// ==== tests/prc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module prc_checker
(
    input wire logic                   clk,
    input wire logic                   reset,
    input wire prc_bus_pkg::bus_addr_t bus_address_out,
    input wire prc_bus_pkg::bus_data_t bus_data_out,
    input wire prc_bus_pkg::bus_cmd_e  bus_status,
    input wire logic                   read,
    input wire logic                   write,
    input wire logic                   bus_request,
    input wire logic                   irq_render_done,
    input wire logic                   irq_copy_complete
);
    import prc_bus_pkg::*;

    localparam int OPS_PER_PAGE = 3 + 2 * LCD_COLUMNS; // Three LCD commands, then read and write
    localparam int OPS_PER_COPY = OPS_PER_PAGE * LCD_PAGES;

    string  test_name       = "none";
    logic   copy_enabled    = 1'b0;
    int     render_period   = 0;
    int     error_count     = 0;
    int     render_rises    = 0;
    int     copies          = 0;
    int     op_index        = 0;
    longint cycle           = 0;
    longint last_render     = 0;
    logic   render_q        = 1'b0;
    logic   copy_q          = 1'b0;
    logic   copy_seen       = 1'b0; // Copy finished since the last render interrupt
    logic   request_flagged = 1'b0;

    function automatic bus_data_t expected_vram_byte(input bus_addr_t addr);
        return addr[23:16] ^ addr[15:8] ^ addr[7:0] ^ 8'h5A;
    endfunction

    task automatic compare_value(input string what, input int expected, input int actual);
        if (expected != actual)
        begin
            error_count++;
            $display("MISMATCH %s %s: expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("ERROR %s: %s", test_name, msg);
    endtask

    task automatic start_test(input string name, input logic copy_en, input int period);
        test_name       = name;
        copy_enabled    = copy_en;
        render_period   = period;
        render_rises    = 0;
        copies          = 0;
        op_index        = 0;
        copy_seen       = 1'b0;
        request_flagged = 1'b0;
    endtask

    task automatic finish_test(input int expected_rises, input int expected_copies);
        compare_value("irq_render_done rises", expected_rises, render_rises);
        compare_value("completed copies", expected_copies, copies);
        compare_value("bus_status at end of test", IDLE, bus_status);
        if (op_index != 0)
            report_failure($sformatf("copy left unfinished after %0d operations", op_index));
    endtask

    // Operation k of one copy as the LCD page sequence defines it
    task automatic expected_op(input int k, output logic is_read, output bus_addr_t addr,
                               output bus_data_t data);
        int page;
        int step;
        int column;
        page    = k / OPS_PER_PAGE;
        step    = k % OPS_PER_PAGE;
        is_read = 1'b0;
        data    = 8'h00;
        addr    = LCD_CMD_ADDR;
        if (step == 0)
            data = 8'h10;
        else if (step == 2)
            data = bus_data_t'(8'hB0 + page);
        else if (step > 2)
        begin
            column = (step - 3) / 2;
            addr   = VRAM_BASE + bus_addr_t'(page * LCD_COLUMNS + column);
            if ((step - 3) % 2 == 0)
                is_read = 1'b1;
            else
            begin
                data = expected_vram_byte(addr);
                addr = LCD_DATA_ADDR;
            end
        end
    endtask

    task automatic check_strobe();
        logic      exp_read;
        bus_addr_t exp_addr;
        bus_data_t exp_data;
        if (!copy_enabled)
            report_failure("master bus strobe while frame copy is disabled");
        else if (op_index >= OPS_PER_COPY)
            report_failure($sformatf("more than %0d operations in one copy", OPS_PER_COPY));
        else
        begin
            expected_op(op_index, exp_read, exp_addr, exp_data);
            if (read != exp_read)
                report_failure($sformatf("copy operation %0d has the wrong direction",
                                         op_index));
            else
            begin
                compare_value($sformatf("op %0d status", op_index),
                              exp_read ? MEM_READ : MEM_WRITE, bus_status);
                compare_value($sformatf("op %0d address", op_index), exp_addr, bus_address_out);
                if (write)
                    compare_value($sformatf("op %0d data", op_index), exp_data, bus_data_out);
            end
            op_index++;
        end
    endtask

    always @(posedge clk)
    begin
        if (!reset)
        begin
            cycle++;
            if (read || write)
                check_strobe();
            if (bus_request && !copy_enabled && !request_flagged)
            begin
                report_failure("bus_request rose while frame copy is disabled");
                request_flagged = 1'b1;
            end
            if (irq_render_done && !render_q)
            begin
                render_rises++;
                if (render_rises > 1)
                    compare_value("render_done spacing in clocks", render_period,
                                  int'(cycle - last_render));
                if (copy_enabled && !copy_seen)
                    report_failure("irq_render_done rose before irq_copy_complete");
                last_render = cycle;
                copy_seen   = 1'b0;
            end
            if (irq_copy_complete && !copy_q)
            begin
                compare_value("operations per copy", OPS_PER_COPY, op_index);
                copies++;
                op_index  = 0;
                copy_seen = 1'b1;
            end
        end
        render_q = irq_render_done;
        copy_q   = irq_copy_complete;
    end

endmodule

`default_nettype wire

// ==== tests/prc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module prc_tb;
    import prc_reg_pkg::*;
    import prc_bus_pkg::*;

    localparam int LINE_PERIOD  = 120;
    localparam int FRAME_CLOCKS = 65 * LINE_PERIOD;
    localparam int NUM_TESTS    = 4;

    typedef struct packed
    {
        logic       do_write;
        logic [7:0] mode_value;
        logic [7:0] mode_expect;
        logic [7:0] rate_value;
        logic [7:0] rate_expect;
        logic       stall;
        logic [3:0] frames;
        logic [3:0] divisor;
    } test_row_t;

    test_row_t   rows [NUM_TESTS];
    string       test_names [NUM_TESTS];
    logic        table_ready = 1'b0;

    logic        clk;
    logic        reset;
    logic        bus_write;
    reg_addr_t   bus_address_in;
    bus_data_t   cpu_data;
    bus_data_t   bus_data_in;
    bus_data_t   bus_data_out;
    bus_addr_t   bus_address_out;
    bus_cmd_e    bus_status;
    logic        write;
    logic        read;
    logic        bus_request;
    logic        bus_ack = 1'b0;
    logic        irq_copy_complete;
    logic        irq_render_done;
    logic        stall_enable;
    logic [31:0] lfsr = 32'he4e8_7ce4;
    logic [1:0]  stall_bits;
    int          failing_tests = 0;

    always #50 clk = ~clk;

    prc #(.LINE_PERIOD(LINE_PERIOD)) i_dut
    (
        .clk(clk), .reset(reset), .bus_write(bus_write), .bus_address_in(bus_address_in),
        .bus_data_in(bus_data_in), .bus_data_out(bus_data_out),
        .bus_address_out(bus_address_out), .bus_status(bus_status), .write(write),
        .read(read), .bus_request(bus_request), .bus_ack(bus_ack),
        .irq_copy_complete(irq_copy_complete), .irq_render_done(irq_render_done)
    );

    prc_checker i_checker
    (
        .clk(clk), .reset(reset), .bus_address_out(bus_address_out),
        .bus_data_out(bus_data_out), .bus_status(bus_status), .read(read), .write(write),
        .bus_request(bus_request), .irq_render_done(irq_render_done),
        .irq_copy_complete(irq_copy_complete)
    );

    bind prc_frame_copy prc_assertions i_assertions
    (
        .clk(clk), .reset(reset), .read(read), .write(write), .bus_ack(bus_ack)
    );

    function automatic bus_data_t vram_byte(input bus_addr_t addr);
        return addr[23:16] ^ addr[15:8] ^ addr[7:0] ^ 8'h5A;
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
    endfunction

    function automatic int error_total();
        return i_checker.error_count + i_dut.i_frame_copy.i_assertions.failure_count;
    endfunction

    // Video RAM answers asynchronously during the read strobe
    assign bus_data_in = read ? vram_byte(bus_address_out) : cpu_data;

    // Arbiter grants while requested
    // Two LFSR bits per clock give a one in four stall
    always @(posedge clk)
    begin
        stall_bits = 2'b00;
        if (stall_enable)
        begin
            stall_bits[0] = lfsr[0];
            lfsr          = lfsr_step(lfsr);
            stall_bits[1] = lfsr[0];
            lfsr          = lfsr_step(lfsr);
        end
        bus_ack <= bus_request && (stall_bits != 2'b11);
    end

    task automatic load_table();
        // do_write, mode in, mode out, rate in, rate out, stall, frames, divisor
        rows[0] = '{1'b0, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0, 4'd0, 4'd1};
        rows[1] = '{1'b1, 8'h37, 8'h37, 8'hF9, 8'h09, 1'b0, 4'd5, 4'd2};
        rows[2] = '{1'b1, 8'h08, 8'h08, 8'h50, 8'h00, 1'b0, 4'd6, 4'd3};
        rows[3] = '{1'b1, 8'hCC, 8'h0C, 8'h38, 8'h08, 1'b1, 4'd2, 4'd2};
        test_names[0] = "reset_read";
        test_names[1] = "rate4_no_copy";
        test_names[2] = "rate0_copy";
        test_names[3] = "stalled_copy";
    endtask

    task automatic write_reg(input reg_addr_t addr, input bus_data_t data);
        @(posedge clk);
        bus_write      <= 1'b1;
        bus_address_in <= addr;
        cpu_data       <= data;
        @(posedge clk);
        bus_write <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_t addr, output bus_data_t value);
        @(posedge clk);
        bus_address_in <= addr;
        @(negedge clk);
        value = bus_data_out;
    endtask

    task automatic read_check(input reg_addr_t addr, input bus_data_t expected, input string what);
        bus_data_t value;
        read_reg(addr, value);
        i_checker.compare_value(what, expected, value);
    endtask

    task automatic run_test(input int t);
        test_row_t row;
        int        errors_before;
        bus_data_t line_value;
        row           = rows[t];
        errors_before = error_total();
        i_checker.start_test(test_names[t], row.mode_expect[3], row.divisor * FRAME_CLOCKS);
        @(posedge clk);
        stall_enable <= row.stall;
        if (row.do_write)
        begin
            write_reg(ADDR_RATE, row.rate_value); // New code clears the skip count
            write_reg(ADDR_MODE, row.mode_value);
        end
        read_check(ADDR_MODE, row.mode_expect, "mode readback");
        read_check(ADDR_RATE, row.rate_expect, "rate readback");
        read_check(24'h002082, 8'h00, "unmapped readback");
        read_reg(ADDR_COUNTER, line_value);
        if (line_value < LINE_FIRST || line_value > LINE_LAST)
            i_checker.report_failure($sformatf("line counter read 0x%0h is out of range",
                                               line_value));
        repeat (row.frames * FRAME_CLOCKS + 4) @(posedge clk);
        i_checker.finish_test(row.frames / row.divisor,
                              row.mode_expect[3] ? row.frames / row.divisor : 0);
        if (error_total() == errors_before)
            $display("Test %-14s PASS", test_names[t]);
        else
        begin
            failing_tests++;
            $display("Test %-14s FAIL, %0d errors", test_names[t], error_total() - errors_before);
        end
    endtask

    initial
    begin
        clk            = 1'b0;
        reset          = 1'b1;
        bus_write      = 1'b0;
        bus_address_in = '0;
        cpu_data       = '0;
        stall_enable   = 1'b0;
        load_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("Summary: %0d tests, %0d failing, %0d errors",
                 NUM_TESTS, failing_tests, error_total());
        if (failing_tests == 0 && error_total() == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

    initial
    begin
        int limit;
        wait (table_ready);
        limit = 8 + 1000;
        for (int t = 0; t < NUM_TESTS; t++)
            limit += rows[t].frames * FRAME_CLOCKS;
        repeat (limit) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d clocks", limit);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/prc_reg_pkg.sv
rtl/prc_bus_pkg.sv
rtl/prc_regs.sv
rtl/prc_frame_timer.sv
rtl/prc_frame_copy.sv
rtl/prc.sv
tests/prc_assertions.sv
tests/prc_checker.sv
tests/prc_tb.sv
